/* design/mips_pkg.sv */
// Shared definitions for the three-stage MIPS integer datapath.
// Holds sizes, opcode and function codes, the instruction word
// layouts and the structs that carry each pipeline register.
// Reached from every file through scoped names.

`default_nettype none

package mips_pkg;

	// ======================================================================
	// sizes
	// ======================================================================
	localparam int XLEN       = 32;
	localparam int REG_AW     = 5;
	localparam int DMEM_WORDS = 16;
	// word index width, taken from address bits above the byte offset
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// ======================================================================
	// opcodes and function codes
	// ======================================================================
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// alu operation class from the main decoder
	typedef enum logic [1:0] {
		ALUOP_ADD  = 2'b00,
		ALUOP_SUB  = 2'b01,
		ALUOP_FUNC = 2'b10
	} aluop_e;

	// ======================================================================
	// instruction word
	// ======================================================================
	typedef struct packed {
		logic [5:0]        opcode;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
		logic [4:0]        shamt;
		logic [5:0]        funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]        opcode;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [15:0]       imm16;
	} i_fmt_t;

	// same 32 bits seen as either format
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	// ======================================================================
	// control and pipeline registers
	// ======================================================================
	typedef struct packed {
		logic   regdst;
		logic   alusrc;
		aluop_e aluop;
		logic   branch;
		logic   memread;
		logic   memwrite;
		logic   memtoreg;
		logic   regwrite;
	} ctrl_t;

	typedef struct packed {
		logic              valid;
		ctrl_t             ctrl;
		logic [XLEN-1:0]   next_pc;
		logic [XLEN-1:0]   rs_data;
		logic [XLEN-1:0]   rt_data;
		logic [XLEN-1:0]   imm_ext;
		logic [REG_AW-1:0] rt_addr;
		logic [REG_AW-1:0] rd_addr;
		logic [5:0]        funct;
	} dec_t;

	typedef struct packed {
		logic              valid;
		logic              memread;
		logic              memwrite;
		logic              memtoreg;
		logic              regwrite;
		logic [XLEN-1:0]   alu_result;
		logic [XLEN-1:0]   store_data;
		logic [REG_AW-1:0] dest_addr;
	} exe_t;

	typedef struct packed {
		logic              valid;
		logic [REG_AW-1:0] addr;
		logic [XLEN-1:0]   data;
	} wb_t;

	typedef struct packed {
		logic            valid;
		logic            taken;
		logic [XLEN-1:0] target;
	} branch_t;

endpackage

`default_nettype wire

/* design/register_bank.sv */
// Thirty-two word register file, two combinational reads and one
// clocked write. Register zero always reads zero. A write pending on
// i_wb is returned to a read of the same register in the same cycle.

`default_nettype none

module register_bank (
	input  wire logic                        i_clk,
	input  wire logic                        i_arst_n,
	input  wire logic [mips_pkg::REG_AW-1:0] i_rs_addr,
	input  wire logic [mips_pkg::REG_AW-1:0] i_rt_addr,
	input  wire mips_pkg::wb_t               i_wb,
	output logic      [mips_pkg::XLEN-1:0]   o_rs_data,
	output logic      [mips_pkg::XLEN-1:0]   o_rt_data
);

	logic [mips_pkg::XLEN-1:0] regs [2**mips_pkg::REG_AW];

	// write port, register zero never written
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < 2**mips_pkg::REG_AW; i++)
				regs[i] <= '0;
		end
		else if (i_wb.valid && (i_wb.addr != '0))
		begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

	// read ports with write bypass
	always_comb
	begin
		if (i_rs_addr == '0)
			o_rs_data = '0;
		else if (i_wb.valid && (i_wb.addr == i_rs_addr))
			o_rs_data = i_wb.data;
		else
			o_rs_data = regs[i_rs_addr];

		if (i_rt_addr == '0)
			o_rt_data = '0;
		else if (i_wb.valid && (i_wb.addr == i_rt_addr))
			o_rt_data = i_wb.data;
		else
			o_rt_data = regs[i_rt_addr];
	end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// Decode stage. Splits the instruction word, generates the control
// bits, sign-extends the immediate and picks up the register operands
// from the bank beside it. Unknown opcodes and function codes leave a
// bubble. The decode result is registered for the execute stage.

`default_nettype none

module decode_stage (
	input  wire logic                        i_clk,
	input  wire logic                        i_arst_n,
	input  wire logic                        i_instr_valid,
	input  wire mips_pkg::instr_u            i_instr,
	input  wire logic [mips_pkg::XLEN-1:0]   i_next_pc,
	input  wire logic [mips_pkg::XLEN-1:0]   i_rs_data,
	input  wire logic [mips_pkg::XLEN-1:0]   i_rt_data,
	output logic      [mips_pkg::REG_AW-1:0] o_rs_addr,
	output logic      [mips_pkg::REG_AW-1:0] o_rt_addr,
	output mips_pkg::dec_t                   o_dec
);

	mips_pkg::ctrl_t ctrl;
	logic            ctrl_ok;
	mips_pkg::dec_t  dec_d;
	mips_pkg::dec_t  dec_q;
	logic            valid_q;

	assign o_rs_addr = i_instr.i_fmt.rs;
	assign o_rt_addr = i_instr.i_fmt.rt;

	// ======================================================================
	// main decoder
	// ======================================================================
	always_comb
	begin
		ctrl    = '0;
		ctrl_ok = 1'b1;
		case (i_instr.i_fmt.opcode)
			mips_pkg::OP_RTYPE:
			begin
				ctrl.regdst   = 1'b1;
				ctrl.aluop    = mips_pkg::ALUOP_FUNC;
				ctrl.regwrite = 1'b1;
				// only the five supported functions
				case (i_instr.r_fmt.funct)
					mips_pkg::FN_ADD,
					mips_pkg::FN_SUB,
					mips_pkg::FN_AND,
					mips_pkg::FN_OR,
					mips_pkg::FN_SLT: ctrl_ok = 1'b1;
					default:          ctrl_ok = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI:
			begin
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = mips_pkg::ALUOP_ADD;
				ctrl.regwrite = 1'b1;
			end
			mips_pkg::OP_LW:
			begin
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = mips_pkg::ALUOP_ADD;
				ctrl.memread  = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.regwrite = 1'b1;
			end
			mips_pkg::OP_SW:
			begin
				ctrl.alusrc   = 1'b1;
				ctrl.aluop    = mips_pkg::ALUOP_ADD;
				ctrl.memwrite = 1'b1;
			end
			mips_pkg::OP_BEQ:
			begin
				ctrl.aluop  = mips_pkg::ALUOP_SUB;
				ctrl.branch = 1'b1;
			end
			default: ctrl_ok = 1'b0;
		endcase
	end

	// next decode register contents
	always_comb
	begin
		dec_d.valid   = i_instr_valid && ctrl_ok;
		dec_d.ctrl    = ctrl;
		dec_d.next_pc = i_next_pc;
		dec_d.rs_data = i_rs_data;
		dec_d.rt_data = i_rt_data;
		// sign extension of imm16
		dec_d.imm_ext = {{(mips_pkg::XLEN-16){i_instr.i_fmt.imm16[15]}},
			i_instr.i_fmt.imm16};
		dec_d.rt_addr = i_instr.r_fmt.rt;
		dec_d.rd_addr = i_instr.r_fmt.rd;
		dec_d.funct   = i_instr.r_fmt.funct;
	end

	// ======================================================================
	// pipeline register
	// ======================================================================
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= dec_d.valid;
	end

	always_ff @(posedge i_clk)
	begin
		dec_q <= dec_d;
	end

	always_comb
	begin
		o_dec       = dec_q;
		o_dec.valid = valid_q;
	end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// Execute stage. Picks the second ALU operand, derives the ALU
// function from the operation class and funct, and runs the ALU.
// Resolves beq from the subtract result and forms the branch target.
// Registers the execute result and the branch report.

`default_nettype none

module execute_stage (
	input  wire logic           i_clk,
	input  wire logic           i_arst_n,
	input  wire mips_pkg::dec_t i_dec,
	output mips_pkg::exe_t      o_exe,
	output mips_pkg::branch_t   o_branch
);

	logic [mips_pkg::XLEN-1:0] op_b;
	logic [5:0]                alu_fn;
	logic [mips_pkg::XLEN-1:0] alu_result;
	logic                      slt_bit;
	logic                      zero;
	mips_pkg::exe_t            exe_d;
	mips_pkg::exe_t            exe_q;
	mips_pkg::branch_t         br_d;
	mips_pkg::branch_t         br_q;
	logic                      exe_valid_q;
	logic                      br_valid_q;

	// ======================================================================
	// alu
	// ======================================================================
	assign op_b    = i_dec.ctrl.alusrc ? i_dec.imm_ext : i_dec.rt_data;
	assign slt_bit = $signed(i_dec.rs_data) < $signed(op_b);

	// class to function, R-type passes funct through
	always_comb
	begin
		case (i_dec.ctrl.aluop)
			mips_pkg::ALUOP_ADD: alu_fn = mips_pkg::FN_ADD;
			mips_pkg::ALUOP_SUB: alu_fn = mips_pkg::FN_SUB;
			default:             alu_fn = i_dec.funct;
		endcase
	end

	always_comb
	begin
		case (alu_fn)
			mips_pkg::FN_ADD: alu_result = i_dec.rs_data + op_b;
			mips_pkg::FN_SUB: alu_result = i_dec.rs_data - op_b;
			mips_pkg::FN_AND: alu_result = i_dec.rs_data & op_b;
			mips_pkg::FN_OR:  alu_result = i_dec.rs_data | op_b;
			mips_pkg::FN_SLT: alu_result = {{(mips_pkg::XLEN-1){1'b0}}, slt_bit};
			default:          alu_result = '0;
		endcase
	end

	// equal operands give a zero difference
	assign zero = (alu_result == '0);

	// ======================================================================
	// next register contents
	// ======================================================================
	always_comb
	begin
		exe_d.valid      = i_dec.valid;
		exe_d.memread    = i_dec.ctrl.memread;
		exe_d.memwrite   = i_dec.ctrl.memwrite;
		exe_d.memtoreg   = i_dec.ctrl.memtoreg;
		exe_d.regwrite   = i_dec.ctrl.regwrite;
		exe_d.alu_result = alu_result;
		exe_d.store_data = i_dec.rt_data;
		exe_d.dest_addr  = i_dec.ctrl.regdst ? i_dec.rd_addr : i_dec.rt_addr;

		br_d.valid  = i_dec.valid && i_dec.ctrl.branch;
		br_d.taken  = zero;
		// word offset relative to next pc
		br_d.target = i_dec.next_pc + {i_dec.imm_ext[mips_pkg::XLEN-3:0], 2'b00};
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			exe_valid_q <= 1'b0;
			br_valid_q  <= 1'b0;
		end
		else
		begin
			exe_valid_q <= exe_d.valid;
			br_valid_q  <= br_d.valid;
		end
	end

	always_ff @(posedge i_clk)
	begin
		exe_q <= exe_d;
		br_q  <= br_d;
	end

	always_comb
	begin
		o_exe          = exe_q;
		o_exe.valid    = exe_valid_q;
		o_branch       = br_q;
		o_branch.valid = br_valid_q;
	end

endmodule

`default_nettype wire

/* design/result_stage.sv */
// Result stage. Holds the sixteen-word data memory, written on the
// clock for a store and read combinationally for a load. Selects the
// loaded word or the ALU result and registers the write-back value.

`default_nettype none

module result_stage (
	input  wire logic           i_clk,
	input  wire logic           i_arst_n,
	input  wire mips_pkg::exe_t i_exe,
	output mips_pkg::wb_t       o_wb
);

	logic [mips_pkg::XLEN-1:0]    dmem [mips_pkg::DMEM_WORDS];
	logic [mips_pkg::DMEM_AW-1:0] word_idx;
	logic [mips_pkg::XLEN-1:0]    load_data;
	mips_pkg::wb_t                wb_d;
	mips_pkg::wb_t                wb_q;
	logic                         wb_valid_q;

	// word address, byte offset dropped
	assign word_idx  = i_exe.alu_result[2 +: mips_pkg::DMEM_AW];
	assign load_data = i_exe.memread ? dmem[word_idx] : '0;

	// ======================================================================
	// data memory
	// ======================================================================
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < mips_pkg::DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (i_exe.valid && i_exe.memwrite)
		begin
			dmem[word_idx] <= i_exe.store_data;
		end
	end

	// write-back select
	always_comb
	begin
		wb_d.valid = i_exe.valid && i_exe.regwrite;
		wb_d.addr  = i_exe.dest_addr;
		wb_d.data  = i_exe.memtoreg ? load_data : i_exe.alu_result;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			wb_valid_q <= 1'b0;
		else
			wb_valid_q <= wb_d.valid;
	end

	always_ff @(posedge i_clk)
	begin
		wb_q <= wb_d;
	end

	always_comb
	begin
		o_wb       = wb_q;
		o_wb.valid = wb_valid_q;
	end

endmodule

`default_nettype wire

/* design/mips_core.sv */
// Top level of the three-stage MIPS datapath. Connects decode,
// execute and result stages with the register bank. The registered
// write-back result feeds the ports and the register bank write port.

`default_nettype none

module mips_core (
	input  wire logic                      i_clk,
	input  wire logic                      i_arst_n,
	input  wire logic                      i_instr_valid,
	input  wire mips_pkg::instr_u          i_instr,
	input  wire logic [mips_pkg::XLEN-1:0] i_next_pc,
	output mips_pkg::wb_t                  o_wb,
	output mips_pkg::branch_t              o_branch
);

	logic [mips_pkg::REG_AW-1:0] rs_addr;
	logic [mips_pkg::REG_AW-1:0] rt_addr;
	logic [mips_pkg::XLEN-1:0]   rs_data;
	logic [mips_pkg::XLEN-1:0]   rt_data;
	mips_pkg::dec_t              dec;
	mips_pkg::exe_t              exe;

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_rs_addr (rs_addr),
		.i_rt_addr (rt_addr),
		.i_wb      (o_wb),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	decode_stage u_decode (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_next_pc     (i_next_pc),
		.i_rs_data     (rs_data),
		.i_rt_data     (rt_data),
		.o_rs_addr     (rs_addr),
		.o_rt_addr     (rt_addr),
		.o_dec         (dec)
	);

	execute_stage u_execute (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_dec    (dec),
		.o_exe    (exe),
		.o_branch (o_branch)
	);

	result_stage u_result (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_exe    (exe),
		.o_wb     (o_wb)
	);

endmodule

`default_nettype wire

/* test/mips_core_tb.sv */
// Testbench for the three-stage MIPS datapath. Builds a table of
// instructions with expected results taken from a shadow copy of the
// registers and data memory, applies it in a loop and compares every
// write-back and branch pulse together with its latency.

`default_nettype none

module mips_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 20;

	typedef enum {K_WB, K_BR, K_NONE} kind_e;

	typedef struct {
		mips_pkg::instr_u  instr;
		logic [31:0]       next_pc;
		kind_e             kind;
		mips_pkg::wb_t     exp_wb;
		mips_pkg::branch_t exp_br;
		bit                burst;
		int                behavior;
	} entry_t;

	logic                      i_clk;
	logic                      i_arst_n;
	logic                      i_instr_valid;
	mips_pkg::instr_u          i_instr;
	logic [mips_pkg::XLEN-1:0] i_next_pc;
	mips_pkg::wb_t             o_wb;
	mips_pkg::branch_t         o_branch;

	entry_t                    tbl[$];
	logic [31:0]               shadow_reg [32];
	logic [31:0]               shadow_mem [mips_pkg::DMEM_WORDS];
	mips_pkg::wb_t             wb_seen[$];
	int                        wb_seen_cyc[$];
	mips_pkg::branch_t         br_seen[$];
	int                        br_seen_cyc[$];
	bit                        test_bad[];
	int                        issue_cyc[];
	int                        cyc = 0;
	int                        cur_beh;
	int                        other_err;

	mips_core dut_i (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_next_pc     (i_next_pc),
		.o_wb          (o_wb),
		.o_branch      (o_branch)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
	begin
		cyc <= cyc + 1;
	end

	// every pulse is logged with the cycle it was seen in
	always @(negedge i_clk)
	begin
		if (o_wb.valid)
		begin
			wb_seen.push_back(o_wb);
			wb_seen_cyc.push_back(cyc);
		end
		if (o_branch.valid)
		begin
			br_seen.push_back(o_branch);
			br_seen_cyc.push_back(cyc);
		end
	end

	// ======================================================================
	// instruction words and expected results
	// ======================================================================
	function automatic logic [31:0] sext(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic logic [31:0] pc_of(input int idx);
		return 32'h400 + 32'(4 * idx);
	endfunction

	function automatic mips_pkg::instr_u itype_word(input logic [5:0] op, input int rs,
		input int rt, input logic [15:0] imm);
		mips_pkg::instr_u u;
		u.i_fmt.opcode = op;
		u.i_fmt.rs     = 5'(rs);
		u.i_fmt.rt     = 5'(rt);
		u.i_fmt.imm16  = imm;
		return u;
	endfunction

	function automatic mips_pkg::instr_u rtype_word(input logic [5:0] fn, input int rd,
		input int rs, input int rt);
		mips_pkg::instr_u u;
		u.r_fmt.opcode = mips_pkg::OP_RTYPE;
		u.r_fmt.rs     = 5'(rs);
		u.r_fmt.rt     = 5'(rt);
		u.r_fmt.rd     = 5'(rd);
		u.r_fmt.shamt  = '0;
		u.r_fmt.funct  = fn;
		return u;
	endfunction

	task automatic add_entry(input mips_pkg::instr_u ins, input kind_e k,
		input mips_pkg::wb_t w, input mips_pkg::branch_t b, input bit burst);
		entry_t e;
		e.instr    = ins;
		e.next_pc  = pc_of(tbl.size());
		e.kind     = k;
		e.exp_wb   = w;
		e.exp_br   = b;
		e.burst    = burst;
		e.behavior = cur_beh;
		tbl.push_back(e);
	endtask

	// register zero stays zero in the shadow copy
	task automatic put_reg(input int r, input logic [31:0] v);
		if (r != 0)
			shadow_reg[r] = v;
	endtask

	task automatic addi_entry(input int rt, input int rs, input logic [15:0] imm,
		input bit burst);
		logic [31:0] v;
		v = shadow_reg[rs] + sext(imm);
		add_entry(itype_word(mips_pkg::OP_ADDI, rs, rt, imm), K_WB, '{1'b1, 5'(rt), v},
			'0, burst);
		put_reg(rt, v);
	endtask

	task automatic rtype_entry(input logic [5:0] fn, input int rd, input int rs,
		input int rt);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		a = shadow_reg[rs];
		b = shadow_reg[rt];
		case (fn)
			mips_pkg::FN_ADD: v = a + b;
			mips_pkg::FN_SUB: v = a - b;
			mips_pkg::FN_AND: v = a & b;
			mips_pkg::FN_OR:  v = a | b;
			default:          v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
		add_entry(rtype_word(fn, rd, rs, rt), K_WB, '{1'b1, 5'(rd), v}, '0, 1'b0);
		put_reg(rd, v);
	endtask

	task automatic lw_entry(input int rt, input int rs, input logic [15:0] imm);
		logic [31:0] addr;
		logic [31:0] v;
		addr = shadow_reg[rs] + sext(imm);
		v    = shadow_mem[addr[5:2]];
		add_entry(itype_word(mips_pkg::OP_LW, rs, rt, imm), K_WB, '{1'b1, 5'(rt), v},
			'0, 1'b0);
		put_reg(rt, v);
	endtask

	task automatic sw_entry(input int rt, input int rs, input logic [15:0] imm);
		logic [31:0] addr;
		addr = shadow_reg[rs] + sext(imm);
		shadow_mem[addr[5:2]] = shadow_reg[rt];
		add_entry(itype_word(mips_pkg::OP_SW, rs, rt, imm), K_NONE, '0, '0, 1'b0);
	endtask

	task automatic beq_entry(input int rs, input int rt, input logic [15:0] imm);
		mips_pkg::branch_t b;
		b.valid  = 1'b1;
		b.taken  = (shadow_reg[rs] == shadow_reg[rt]);
		b.target = pc_of(tbl.size()) + (sext(imm) << 2);
		add_entry(itype_word(mips_pkg::OP_BEQ, rs, rt, imm), K_BR, '0, b, 1'b0);
	endtask

	task automatic build_table();
		foreach (shadow_reg[r])
			shadow_reg[r] = '0;
		foreach (shadow_mem[m])
			shadow_mem[m] = '0;
		// every register reads zero after reset
		cur_beh = 1;
		for (int r = 0; r < 32; r++)
			rtype_entry(mips_pkg::FN_ADD, r, r, 0);
		cur_beh = 2;
		addi_entry(1, 0, 16'h0005, 1'b0);
		addi_entry(2, 0, 16'hfff0, 1'b0);
		addi_entry(3, 1, 16'h8000, 1'b0);
		addi_entry(4, 2, 16'($urandom), 1'b0);
		addi_entry(10, 3, 16'($urandom), 1'b0);
		addi_entry(0, 1, 16'h0123, 1'b0);
		rtype_entry(mips_pkg::FN_ADD, 9, 0, 0);
		// signed operands on either side of zero with shared set bits
		cur_beh = 3;
		addi_entry(5, 0, 16'hfffd, 1'b0);
		addi_entry(6, 0, 16'h0006, 1'b0);
		rtype_entry(mips_pkg::FN_ADD, 7, 5, 6);
		rtype_entry(mips_pkg::FN_SUB, 8, 5, 6);
		rtype_entry(mips_pkg::FN_AND, 11, 5, 6);
		rtype_entry(mips_pkg::FN_OR, 12, 5, 6);
		rtype_entry(mips_pkg::FN_SLT, 13, 5, 6);
		rtype_entry(mips_pkg::FN_SLT, 14, 6, 5);
		add_entry(rtype_word(6'h26, 15, 5, 6), K_NONE, '0, '0, 1'b0);
		add_entry(itype_word(6'h3f, 1, 15, 16'h0001), K_NONE, '0, '0, 1'b0);
		cur_beh = 4;
		sw_entry(5, 0, 16'h0008);
		sw_entry(6, 0, 16'h0014);
		lw_entry(16, 0, 16'h0008);
		lw_entry(17, 0, 16'h0014);
		lw_entry(18, 2, 16'h0018);
		lw_entry(19, 0, 16'h0020);
		cur_beh = 5;
		beq_entry(1, 1, 16'h0010);
		beq_entry(5, 6, 16'h0003);
		beq_entry(0, 9, 16'hfffc);
		// three independent addi issued back to back
		cur_beh = 6;
		addi_entry(20 + int'($urandom_range(3)), 1 + int'($urandom_range(5)),
			16'($urandom), 1'b1);
		addi_entry(24 + int'($urandom_range(3)), 1 + int'($urandom_range(5)),
			16'($urandom), 1'b1);
		addi_entry(28 + int'($urandom_range(3)), 1 + int'($urandom_range(5)),
			16'($urandom), 1'b0);
	endtask

	// ======================================================================
	// compare tasks
	// ======================================================================
	task automatic check_wb(input int t, input mips_pkg::wb_t exp, input mips_pkg::wb_t got);
		if (got !== exp)
		begin
			$display(
				"mismatch at %0t: test %0d wb addr=%0d data=%h, expected addr=%0d data=%h",
				$time, t, got.addr, got.data, exp.addr, exp.data);
			test_bad[t] = 1'b1;
		end
	endtask

	task automatic check_branch(input int t, input mips_pkg::branch_t exp,
		input mips_pkg::branch_t got);
		if (got !== exp)
		begin
			$display(
				"mismatch at %0t: test %0d branch taken=%b target=%h, expected taken=%b target=%h",
				$time, t, got.taken, got.target, exp.taken, exp.target);
			test_bad[t] = 1'b1;
		end
	endtask

	task automatic compare_latency(input int t, input int got_cyc, input int exp_cyc);
		if (got_cyc != exp_cyc)
		begin
			$display("mismatch at %0t: test %0d pulse in cycle %0d, expected cycle %0d",
				$time, t, got_cyc, exp_cyc);
			test_bad[t] = 1'b1;
		end
	endtask

	// ======================================================================
	// table loop
	// ======================================================================
	task automatic collect(input int j);
		int n;
		n = 0;
		if (tbl[j].kind == K_WB)
		begin
			while (wb_seen.size() == 0 && n < WAIT_LIMIT)
			begin
				@(posedge i_clk);
				n++;
			end
			if (wb_seen.size() == 0)
			begin
				$display("timeout at %0t: test %0d never produced its write-back pulse",
					$time, j);
				test_bad[j] = 1'b1;
			end
			else
			begin
				check_wb(j, tbl[j].exp_wb, wb_seen.pop_front());
				compare_latency(j, wb_seen_cyc.pop_front(), issue_cyc[j] + 3);
			end
		end
		else if (tbl[j].kind == K_BR)
		begin
			while (br_seen.size() == 0 && n < WAIT_LIMIT)
			begin
				@(posedge i_clk);
				n++;
			end
			if (br_seen.size() == 0)
			begin
				$display("timeout at %0t: test %0d never produced its branch pulse",
					$time, j);
				test_bad[j] = 1'b1;
			end
			else
			begin
				check_branch(j, tbl[j].exp_br, br_seen.pop_front());
				compare_latency(j, br_seen_cyc.pop_front(), issue_cyc[j] + 2);
			end
		end
	endtask

	task automatic run_table();
		int idx;
		int first;
		bit more;
		idx = 0;
		while (idx < tbl.size())
		begin
			first = idx;
			more  = 1'b1;
			while (more)
			begin
				@(posedge i_clk);
				i_instr_valid <= 1'b1;
				i_instr       <= tbl[idx].instr;
				i_next_pc     <= tbl[idx].next_pc;
				@(negedge i_clk);
				issue_cyc[idx] = cyc;
				idx++;
				more = tbl[idx-1].burst && (idx < tbl.size());
			end
			@(posedge i_clk);
			i_instr_valid <= 1'b0;
			for (int j = first; j < idx; j++)
				collect(j);
			// quiet window for stray pulses
			repeat (4) @(posedge i_clk);
			if (wb_seen.size() != 0 || br_seen.size() != 0)
			begin
				$display("unexpected write-back or branch pulse after test %0d", idx - 1);
				test_bad[idx-1] = 1'b1;
				wb_seen.delete();
				wb_seen_cyc.delete();
				br_seen.delete();
				br_seen_cyc.delete();
			end
			for (int j = first; j < idx; j++)
				$display("test %0d behavior %0d %s", j, tbl[j].behavior,
					test_bad[j] ? "failed" : "ok");
		end
	endtask

	initial
	begin
		int n_bad;
		void'($urandom(52657));
		i_arst_n      = 1'b0;
		i_instr_valid = 1'b0;
		i_instr       = '0;
		i_next_pc     = '0;
		other_err     = 0;
		n_bad         = 0;
		build_table();
		test_bad  = new[tbl.size()];
		issue_cyc = new[tbl.size()];
		repeat (10) @(posedge i_clk);
		i_arst_n <= 1'b1;
		repeat (3) @(posedge i_clk);
		if (wb_seen.size() != 0 || br_seen.size() != 0)
		begin
			$display("a write-back or branch pulse was raised during or after reset");
			other_err++;
		end
		$display("test reset idle %s", (other_err == 0) ? "ok" : "failed");
		run_table();
		n_bad = other_err;
		foreach (test_bad[j])
		begin
			if (test_bad[j])
				n_bad++;
		end
		$display("tests %0d, passed %0d, failed %0d", tbl.size() + 1,
			tbl.size() + 1 - n_bad, n_bad);
		if (n_bad == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* mips_core.f */
design/mips_pkg.sv
design/register_bank.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/mips_core.sv
test/mips_core_tb.sv
